// File: source/bridge_config.svh
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// inst, cached data, uncached data
`define BRIDGE_CHANNELS 3
`define AXI_ID_W 4

// mips fixed-mapped segments
`define KSEG0_BASE 32'h8000_0000
`define KSEG1_BASE 32'hA000_0000

`endif

// File: source/bridge_pkg.sv
`default_nettype none
`include "bridge_config.svh"

package bridge_pkg;

    typedef logic [31:0]          word_t;
    typedef logic [1:0]           size_t;
    typedef logic [`AXI_ID_W-1:0] axi_id_t;

    // core transfer sizes
    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    typedef struct packed {
        logic  req;
        logic  wr;
        size_t size;
        word_t addr;
        word_t wdata;
    } sramx_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t rdata;
    } sramx_resp_t;

    // channel index doubles as the axi id
    typedef enum logic [1:0] {
        CH_INST     = 2'd0,
        CH_DATA     = 2'd1,
        CH_UNCACHED = 2'd2
    } chan_e;

endpackage

`default_nettype wire

// File: source/sramx_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sramx_if;
    import bridge_pkg::*;

    logic  req;
    logic  wr;
    size_t size;
    word_t addr;
    word_t wdata;
    word_t rdata;
    logic  addr_ok;
    logic  data_ok;

    modport master (
        output req, wr, size, addr, wdata,
        input  rdata, addr_ok, data_ok
    );

    modport slave (
        input  req, wr, size, addr, wdata,
        output rdata, addr_ok, data_ok
    );

endinterface

`default_nettype wire

// File: source/axi_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_if;
    import bridge_pkg::*;

    // single beat only so len and burst are added at the port
    axi_id_t    arid;
    word_t      araddr;
    logic [2:0] arsize;
    logic       arvalid;
    logic       arready;

    word_t      rdata;
    logic [1:0] rresp;
    logic       rlast;
    logic       rvalid;
    logic       rready;

    axi_id_t    awid;
    word_t      awaddr;
    logic [2:0] awsize;
    logic       awvalid;
    logic       awready;

    word_t      wdata;
    logic [3:0] wstrb;
    logic       wlast;
    logic       wvalid;
    logic       wready;

    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;

    modport master (
        output arid, araddr, arsize, arvalid, rready,
        output awid, awaddr, awsize, awvalid, wdata, wstrb, wlast, wvalid, bready,
        input  arready, rdata, rresp, rlast, rvalid, awready, wready, bresp, bvalid
    );

    modport slave (
        input  arid, araddr, arsize, arvalid, rready,
        input  awid, awaddr, awsize, awvalid, wdata, wstrb, wlast, wvalid, bready,
        output arready, rdata, rresp, rlast, rvalid, awready, wready, bresp, bvalid
    );

endinterface

`default_nettype wire

// File: source/addr_dispatch.sv
`timescale 1ns/1ps
`default_nettype none
`include "bridge_config.svh"

module addr_dispatch (
    input  logic    aclk,
    input  logic    rst_n,
    sramx_if.slave  inst,
    sramx_if.slave  data,
    sramx_if.master chan [`BRIDGE_CHANNELS]
);
    import bridge_pkg::*;

    localparam word_t KSEG_END = `KSEG1_BASE + 32'h2000_0000;

    logic  inst_busy;
    logic  data_busy;
    logic  data_uc;
    logic  data_uc_q;
    logic  inst_take;
    logic  data_take;
    word_t data_paddr;

    // kseg0/kseg1 fold onto the low 512M
    function automatic word_t translate(input word_t vaddr);
        if (vaddr >= `KSEG0_BASE && vaddr < KSEG_END) begin
            return {3'b000, vaddr[28:0]};
        end
        return vaddr;
    endfunction

    assign data_uc    = data.addr >= `KSEG1_BASE && data.addr < KSEG_END;
    assign data_paddr = translate(data.addr);

    assign chan[CH_INST].req   = inst.req && !inst_busy;
    assign chan[CH_INST].wr    = inst.wr;
    assign chan[CH_INST].size  = inst.size;
    assign chan[CH_INST].addr  = translate(inst.addr);
    assign chan[CH_INST].wdata = inst.wdata;

    assign chan[CH_DATA].req   = data.req && !data_busy && !data_uc;
    assign chan[CH_DATA].wr    = data.wr;
    assign chan[CH_DATA].size  = data.size;
    assign chan[CH_DATA].addr  = data_paddr;
    assign chan[CH_DATA].wdata = data.wdata;

    assign chan[CH_UNCACHED].req   = data.req && !data_busy && data_uc;
    assign chan[CH_UNCACHED].wr    = data.wr;
    assign chan[CH_UNCACHED].size  = data.size;
    assign chan[CH_UNCACHED].addr  = data_paddr;
    assign chan[CH_UNCACHED].wdata = data.wdata;

    assign inst.addr_ok = chan[CH_INST].addr_ok && !inst_busy;
    assign inst.data_ok = chan[CH_INST].data_ok && inst_busy;
    assign inst.rdata   = chan[CH_INST].rdata;

    assign data.addr_ok = !data_busy &&
                          (data_uc ? chan[CH_UNCACHED].addr_ok : chan[CH_DATA].addr_ok);
    // response comes from whichever channel took the request
    assign data.data_ok = data_busy &&
                          (data_uc_q ? chan[CH_UNCACHED].data_ok : chan[CH_DATA].data_ok);
    assign data.rdata   = data_uc_q ? chan[CH_UNCACHED].rdata : chan[CH_DATA].rdata;

    assign inst_take = inst.req && inst.addr_ok;
    assign data_take = data.req && data.addr_ok;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            inst_busy <= 1'b0;
            data_busy <= 1'b0;
            data_uc_q <= 1'b0;
        end else begin
            if (inst_take) begin
                inst_busy <= 1'b1;
            end else if (inst.data_ok) begin
                inst_busy <= 1'b0;
            end
            if (data_take) begin
                data_busy <= 1'b1;
                data_uc_q <= data_uc;
            end else if (data.data_ok) begin
                data_busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/sramx_to_axi.sv
`timescale 1ns/1ps
`default_nettype none

module sramx_to_axi (
    input  logic                aclk,
    input  logic                rst_n,
    input  bridge_pkg::axi_id_t id,
    sramx_if.slave              core,
    axi_if.master               axi
);
    import bridge_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_RESP,
        S_DONE
    } state_e;

    state_e state;

    logic  ar_valid;
    logic  aw_valid;
    logic  w_valid;
    logic  ar_left;
    logic  aw_left;
    logic  w_left;
    logic  accept;
    logic  resp_done;
    logic  wr_q;
    size_t size_q;
    word_t addr_q;
    word_t wdata_q;
    word_t rdata_q;

    function automatic logic [3:0] byte_strobe(input size_t size, input logic [1:0] offset);
        case (size)
            SIZE_BYTE: return 4'b0001 << offset;
            SIZE_HALF: return offset[1] ? 4'b1100 : 4'b0011;
            SIZE_WORD: return 4'b1111;
            default:   return 4'b0000;
        endcase
    endfunction

    assign accept = core.req && core.addr_ok;

    // beats still waiting after this cycle
    assign ar_left = ar_valid && !axi.arready;
    assign aw_left = aw_valid && !axi.awready;
    assign w_left  = w_valid && !axi.wready;

    assign resp_done = wr_q ? (axi.bvalid && axi.bready)
                            : (axi.rvalid && axi.rready && axi.rlast);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            ar_valid <= 1'b0;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state    <= S_ADDR;
                        ar_valid <= !core.wr;
                        aw_valid <= core.wr;
                        w_valid  <= core.wr;
                    end
                end
                S_ADDR: begin
                    // aw and w may be taken in different cycles
                    ar_valid <= ar_left;
                    aw_valid <= aw_left;
                    w_valid  <= w_left;
                    if (!ar_left && !aw_left && !w_left) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (resp_done) begin
                        state <= S_DONE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            wr_q    <= core.wr;
            size_q  <= core.size;
            addr_q  <= core.addr;
            wdata_q <= core.wdata;
        end
        if (axi.rvalid && axi.rready) begin
            rdata_q <= axi.rdata;
        end
    end

    assign core.addr_ok = state == S_IDLE;
    assign core.data_ok = state == S_DONE;
    assign core.rdata   = rdata_q;

    assign axi.arid    = id;
    assign axi.araddr  = addr_q;
    assign axi.arsize  = {1'b0, size_q};
    assign axi.arvalid = ar_valid;
    assign axi.rready  = state == S_RESP && !wr_q;

    assign axi.awid    = id;
    assign axi.awaddr  = addr_q;
    assign axi.awsize  = {1'b0, size_q};
    assign axi.awvalid = aw_valid;
    assign axi.wdata   = wdata_q;
    assign axi.wstrb   = byte_strobe(size_q, addr_q[1:0]);
    assign axi.wlast   = 1'b1;
    assign axi.wvalid  = w_valid;
    assign axi.bready  = state == S_RESP && wr_q;

endmodule

`default_nettype wire

// File: source/axi_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "bridge_config.svh"

module axi_arbiter (
    input  logic                aclk,
    input  logic                rst_n,
    axi_if.slave                bus [`BRIDGE_CHANNELS],
    output bridge_pkg::axi_id_t arid, awid, wid,
    output bridge_pkg::word_t   araddr, awaddr, wdata,
    output logic [3:0]          arlen, awlen, arcache, awcache, wstrb,
    output logic [2:0]          arsize, awsize, arprot, awprot,
    output logic [1:0]          arburst, awburst, arlock, awlock,
    output logic                arvalid, awvalid, wvalid, wlast, rready, bready,
    input  bridge_pkg::axi_id_t rid, bid,
    input  bridge_pkg::word_t   rdata,
    input  logic [1:0]          rresp, bresp,
    input  logic                arready, awready, wready, rvalid, rlast, bvalid
);
    import bridge_pkg::*;

    localparam int N     = `BRIDGE_CHANNELS;
    localparam int IDX_W = $clog2(N);

    typedef logic [IDX_W-1:0] idx_t;

    logic [N-1:0] ar_valid_v;
    logic [N-1:0] aw_valid_v;
    logic [N-1:0] w_valid_v;
    logic [N-1:0] w_last_v;
    logic [N-1:0] r_ready_v;
    logic [N-1:0] b_ready_v;
    axi_id_t      ar_id_v   [N];
    axi_id_t      aw_id_v   [N];
    word_t        ar_addr_v [N];
    word_t        aw_addr_v [N];
    word_t        w_data_v  [N];
    logic [2:0]   ar_size_v [N];
    logic [2:0]   aw_size_v [N];
    logic [3:0]   w_strb_v  [N];

    idx_t rd_pick, rd_sel, rd_owner, rd_last;
    idx_t wr_pick, wr_sel, wr_owner, wr_last;
    logic rd_hold, wr_hold;
    logic rd_done, wr_done;

    // first valid requester after the last grant
    function automatic idx_t rr_pick(input logic [N-1:0] valid, input idx_t last);
        idx_t pick;
        int   idx;
        pick = last;
        for (int k = N; k >= 1; k--) begin
            idx = (int'(last) + k) % N;
            if (valid[idx]) begin
                pick = idx_t'(idx);
            end
        end
        return pick;
    endfunction

    for (genvar i = 0; i < N; i++) begin : g_bus
        assign ar_valid_v[i] = bus[i].arvalid;
        assign ar_id_v[i]    = bus[i].arid;
        assign ar_addr_v[i]  = bus[i].araddr;
        assign ar_size_v[i]  = bus[i].arsize;
        assign r_ready_v[i]  = bus[i].rready;
        assign aw_valid_v[i] = bus[i].awvalid;
        assign aw_id_v[i]    = bus[i].awid;
        assign aw_addr_v[i]  = bus[i].awaddr;
        assign aw_size_v[i]  = bus[i].awsize;
        assign w_valid_v[i]  = bus[i].wvalid;
        assign w_data_v[i]   = bus[i].wdata;
        assign w_strb_v[i]   = bus[i].wstrb;
        assign w_last_v[i]   = bus[i].wlast;
        assign b_ready_v[i]  = bus[i].bready;

        assign bus[i].arready = arready && rd_sel == idx_t'(i);
        assign bus[i].awready = awready && wr_sel == idx_t'(i);
        assign bus[i].wready  = wready && wr_sel == idx_t'(i);

        // responses steered by id
        assign bus[i].rvalid = rvalid && rid == axi_id_t'(i);
        assign bus[i].rdata  = rdata;
        assign bus[i].rresp  = rresp;
        assign bus[i].rlast  = rlast;
        assign bus[i].bvalid = bvalid && bid == axi_id_t'(i);
        assign bus[i].bresp  = bresp;
    end

    assign rd_pick = rr_pick(ar_valid_v, rd_last);
    assign rd_sel  = rd_hold ? rd_owner : rd_pick;
    assign wr_pick = rr_pick(aw_valid_v | w_valid_v, wr_last);
    assign wr_sel  = wr_hold ? wr_owner : wr_pick;

    assign arid    = ar_id_v[rd_sel];
    assign araddr  = ar_addr_v[rd_sel];
    assign arsize  = ar_size_v[rd_sel];
    assign arvalid = ar_valid_v[rd_sel];
    assign arlen   = 4'd0;
    assign arburst = AXI_BURST_INCR;
    assign arlock  = 2'b00;
    assign arcache = 4'b0000;
    assign arprot  = 3'b000;
    assign rready  = (rid < axi_id_t'(N)) ? r_ready_v[idx_t'(rid)] : 1'b0;

    assign awid    = aw_id_v[wr_sel];
    assign awaddr  = aw_addr_v[wr_sel];
    assign awsize  = aw_size_v[wr_sel];
    assign awvalid = aw_valid_v[wr_sel];
    assign awlen   = 4'd0;
    assign awburst = AXI_BURST_INCR;
    assign awlock  = 2'b00;
    assign awcache = 4'b0000;
    assign awprot  = 3'b000;
    assign wid     = aw_id_v[wr_sel];
    assign wdata   = w_data_v[wr_sel];
    assign wstrb   = w_strb_v[wr_sel];
    assign wlast   = w_last_v[wr_sel];
    assign wvalid  = w_valid_v[wr_sel];
    assign bready  = (bid < axi_id_t'(N)) ? b_ready_v[idx_t'(bid)] : 1'b0;

    assign rd_done = rvalid && rready && rlast;
    assign wr_done = bvalid && bready;

    // grant locks once valid shows and frees at the response
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_hold  <= 1'b0;
            rd_owner <= '0;
            rd_last  <= idx_t'(N - 1);
        end else if (rd_done) begin
            rd_hold <= 1'b0;
        end else if (!rd_hold && arvalid) begin
            rd_hold  <= 1'b1;
            rd_owner <= rd_pick;
            rd_last  <= rd_pick;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_hold  <= 1'b0;
            wr_owner <= '0;
            wr_last  <= idx_t'(N - 1);
        end else if (wr_done) begin
            wr_hold <= 1'b0;
        end else if (!wr_hold && (awvalid || wvalid)) begin
            wr_hold  <= 1'b1;
            wr_owner <= wr_pick;
            wr_last  <= wr_pick;
        end
    end

endmodule

`default_nettype wire

// File: source/sramx_axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none
`include "bridge_config.svh"

module sramx_axi_bridge (
    input  logic                aclk,
    input  logic                rst_n,

    input  logic                inst_req, inst_wr,
    input  bridge_pkg::size_t   inst_size,
    input  bridge_pkg::word_t   inst_addr, inst_wdata,
    output bridge_pkg::word_t   inst_rdata,
    output logic                inst_addr_ok, inst_data_ok,

    input  logic                data_req, data_wr,
    input  bridge_pkg::size_t   data_size,
    input  bridge_pkg::word_t   data_addr, data_wdata,
    output bridge_pkg::word_t   data_rdata,
    output logic                data_addr_ok, data_data_ok,

    output bridge_pkg::axi_id_t arid, awid, wid,
    output bridge_pkg::word_t   araddr, awaddr, wdata,
    output logic [3:0]          arlen, awlen, arcache, awcache, wstrb,
    output logic [2:0]          arsize, awsize, arprot, awprot,
    output logic [1:0]          arburst, awburst, arlock, awlock,
    output logic                arvalid, awvalid, wvalid, wlast, rready, bready,
    input  bridge_pkg::axi_id_t rid, bid,
    input  bridge_pkg::word_t   rdata,
    input  logic [1:0]          rresp, bresp,
    input  logic                arready, awready, wready, rvalid, rlast, bvalid
);
    import bridge_pkg::*;

    sramx_if inst ();
    sramx_if data ();
    sramx_if chan [`BRIDGE_CHANNELS] ();
    axi_if   bus  [`BRIDGE_CHANNELS] ();

    assign inst.req      = inst_req;
    assign inst.wr       = inst_wr;
    assign inst.size     = inst_size;
    assign inst.addr     = inst_addr;
    assign inst.wdata    = inst_wdata;
    assign inst_rdata    = inst.rdata;
    assign inst_addr_ok  = inst.addr_ok;
    assign inst_data_ok  = inst.data_ok;

    assign data.req      = data_req;
    assign data.wr       = data_wr;
    assign data.size     = data_size;
    assign data.addr     = data_addr;
    assign data.wdata    = data_wdata;
    assign data_rdata    = data.rdata;
    assign data_addr_ok  = data.addr_ok;
    assign data_data_ok  = data.data_ok;

    addr_dispatch dispatch_inst (.*);

    // one converter per channel with the id set to its index
    for (genvar i = 0; i < `BRIDGE_CHANNELS; i++) begin : g_conv
        sramx_to_axi conv_inst (
            .aclk  (aclk),
            .rst_n (rst_n),
            .id    (axi_id_t'(i)),
            .core  (chan[i]),
            .axi   (bus[i])
        );
    end

    axi_arbiter arbiter_inst (.*);

endmodule

`default_nettype wire

// File: testbench/tb_bridge.sv
`timescale 1ns/1ps
`default_nettype none
`include "bridge_config.svh"

module tb_bridge;
    import bridge_pkg::*;

    localparam int N_REQ   = 200;
    localparam int TIMEOUT = 300;

    logic       aclk;
    logic       rst_n;
    logic       inst_req, inst_wr, data_req, data_wr;
    size_t      inst_size, data_size;
    word_t      inst_addr, inst_wdata, data_addr, data_wdata;
    word_t      inst_rdata, data_rdata;
    logic       inst_addr_ok, inst_data_ok, data_addr_ok, data_data_ok;
    axi_id_t    arid, awid, wid;
    word_t      araddr, awaddr, wdata;
    logic [3:0] arlen, awlen, arcache, awcache, wstrb;
    logic [2:0] arsize, awsize, arprot, awprot;
    logic [1:0] arburst, awburst, arlock, awlock, rresp, bresp;
    logic       arvalid, awvalid, wvalid, wlast, rready, bready;
    logic       rlast;

    axi_id_t    rid     = '0;
    axi_id_t    bid     = '0;
    word_t      rdata   = '0;
    logic       arready = 1'b0;
    logic       awready = 1'b0;
    logic       wready  = 1'b0;
    logic       rvalid  = 1'b0;
    logic       bvalid  = 1'b0;

    int errors = 0;
    int checks = 0;

    // both arrays keyed by physical word index
    word_t axi_mem   [word_t];
    word_t model_mem [word_t];

    // what the port currently has in flight
    word_t      inst_exp_pa;
    word_t      data_exp_pa;
    axi_id_t    data_exp_id;
    size_t      data_exp_size;
    logic [3:0] data_exp_strb;
    word_t      inst_q [$];
    sramx_req_t data_q [$];

    // responder state
    logic       rd_busy, aw_got, w_got;
    word_t      rd_pa, wr_pa, wr_data;
    logic [3:0] wr_strb;
    int         ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;

    sramx_axi_bridge dut (.*);

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    function automatic word_t fill_word(input word_t pa);
        return {pa[15:0], pa[31:16]} ^ 32'h3c5a_a5c3 ^ (pa << 7);
    endfunction

    // 1 << size bytes starting at the offset
    function automatic logic [3:0] strobe_of(input size_t size, input logic [1:0] off);
        return 4'(((1 << (1 << size)) - 1) << off);
    endfunction

    function automatic word_t merge(input word_t old, input word_t new_w, input logic [3:0] strb);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic word_t mem_read(input word_t pa);
        word_t key;
        key = pa >> 2;
        return axi_mem.exists(key) ? axi_mem[key] : fill_word({pa[31:2], 2'b00});
    endfunction

    function automatic word_t model_read(input word_t pa);
        word_t key;
        key = pa >> 2;
        return model_mem.exists(key) ? model_mem[key] : fill_word({pa[31:2], 2'b00});
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic check_idle();
        check_value("arvalid", word_t'(arvalid), 32'd0);
        check_value("awvalid", word_t'(awvalid), 32'd0);
        check_value("wvalid", word_t'(wvalid), 32'd0);
        check_value("inst_data_ok", word_t'(inst_data_ok), 32'd0);
        check_value("data_data_ok", word_t'(data_data_ok), 32'd0);
    endtask

    // single beat incr, normal access, no cache hints
    task automatic check_ar_attrs();
        check_value("arlen", word_t'(arlen), 32'd0);
        check_value("arburst", word_t'(arburst), 32'd1);
        check_value("arlock", word_t'(arlock), 32'd0);
        check_value("arcache", word_t'(arcache), 32'd0);
        check_value("arprot", word_t'(arprot), 32'd0);
    endtask

    task automatic check_aw_attrs();
        check_value("awlen", word_t'(awlen), 32'd0);
        check_value("awburst", word_t'(awburst), 32'd1);
        check_value("awlock", word_t'(awlock), 32'd0);
        check_value("awcache", word_t'(awcache), 32'd0);
        check_value("awprot", word_t'(awprot), 32'd0);
    endtask

    // read side of the axi memory
    always @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rid     <= '0;
            rdata   <= '0;
            rd_busy <= 1'b0;
            ar_cnt  <= 0;
            r_cnt   <= 0;
        end else begin
            if (rd_busy && arvalid) begin
                errors++;
                $display("second read presented at %0t while one is outstanding", $time);
            end
            if (arvalid && arready) begin
                arready <= 1'b0;
                rd_busy <= 1'b1;
                rd_pa   <= araddr;
                rid     <= arid;
                r_cnt   <= $urandom % 4;
                check_ar_attrs();
                if (arid == axi_id_t'(CH_INST)) begin
                    check_value("araddr", araddr, inst_exp_pa);
                    check_value("arsize", word_t'(arsize), 32'd2);
                end else begin
                    check_value("arid", word_t'(arid), word_t'(data_exp_id));
                    check_value("araddr", araddr, data_exp_pa);
                    check_value("arsize", word_t'(arsize), word_t'(data_exp_size));
                end
            end else if (!rd_busy && !arready) begin
                if (ar_cnt == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_cnt <= ar_cnt - 1;
                end
            end
            if (rd_busy && !rvalid) begin
                if (r_cnt == 0) begin
                    rvalid <= 1'b1;
                    rdata  <= mem_read(rd_pa);
                end else begin
                    r_cnt <= r_cnt - 1;
                end
            end
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_busy <= 1'b0;
                ar_cnt  <= $urandom % 4;
            end
        end
    end

    // write side takes aw and w independently
    always @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bid     <= '0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            aw_cnt  <= 0;
            w_cnt   <= 0;
            b_cnt   <= 0;
        end else begin
            if (aw_got && awvalid) begin
                errors++;
                $display("second write address presented at %0t while one is outstanding",
                         $time);
            end
            if (w_got && wvalid) begin
                errors++;
                $display("second write data presented at %0t while one is outstanding", $time);
            end
            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_got  <= 1'b1;
                wr_pa   <= awaddr;
                bid     <= awid;
                check_aw_attrs();
                check_value("awid", word_t'(awid), word_t'(data_exp_id));
                check_value("awaddr", awaddr, data_exp_pa);
                check_value("awsize", word_t'(awsize), word_t'(data_exp_size));
            end else if (!aw_got && !awready) begin
                if (aw_cnt == 0) begin
                    awready <= 1'b1;
                end else begin
                    aw_cnt <= aw_cnt - 1;
                end
            end
            if (wvalid && wready) begin
                wready  <= 1'b0;
                w_got   <= 1'b1;
                wr_data <= wdata;
                wr_strb <= wstrb;
                check_value("wstrb", word_t'(wstrb), word_t'(data_exp_strb));
                check_value("wid", word_t'(wid), word_t'(data_exp_id));
                check_value("wlast", word_t'(wlast), 32'd1);
            end else if (!w_got && !wready) begin
                if (w_cnt == 0) begin
                    wready <= 1'b1;
                end else begin
                    w_cnt <= w_cnt - 1;
                end
            end
            if (aw_got && w_got && !bvalid) begin
                if (b_cnt == 0) begin
                    axi_mem[wr_pa >> 2] = merge(mem_read(wr_pa), wr_data, wr_strb);
                    bvalid <= 1'b1;
                end else begin
                    b_cnt <= b_cnt - 1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                aw_cnt <= $urandom % 4;
                w_cnt  <= $urandom % 4;
                b_cnt  <= $urandom % 4;
            end
        end
    end

    // responses come back in issue order with one per request
    always @(negedge aclk) begin : response_check
        word_t      pa;
        sramx_req_t e;
        if (rst_n && inst_data_ok) begin
            if (inst_q.size() == 0) begin
                errors++;
                $display("inst data_ok at %0t with no request outstanding", $time);
            end else begin
                pa = inst_q.pop_front();
                check_value("inst_rdata", inst_rdata, model_read(pa));
            end
        end
        if (rst_n && data_data_ok) begin
            if (data_q.size() == 0) begin
                errors++;
                $display("data data_ok at %0t with no request outstanding", $time);
            end else begin
                e = data_q.pop_front();
                if (e.wr) begin
                    model_mem[e.addr >> 2] = merge(model_read(e.addr), e.wdata,
                                                   strobe_of(e.size, e.addr[1:0]));
                end else begin
                    check_value("data_rdata", data_rdata, model_read(e.addr));
                end
            end
        end
    end

    task automatic run_inst();
        word_t va;
        int    t;
        for (int n = 0; n < N_REQ; n++) begin
            va = (($urandom % 2) ? `KSEG1_BASE : `KSEG0_BASE) | word_t'(($urandom % 256) << 2);
            inst_exp_pa = va & 32'h1fff_ffff;
            @(posedge aclk);
            inst_req  <= 1'b1;
            inst_addr <= va;
            t = 0;
            do begin
                @(negedge aclk);
                t++;
                if (t > TIMEOUT) timed_out("inst addr_ok");
            end while (!inst_addr_ok);
            inst_q.push_back(inst_exp_pa);
            @(posedge aclk);
            inst_req <= 1'b0;
            t = 0;
            do begin
                @(negedge aclk);
                t++;
                if (t > TIMEOUT) timed_out("inst data_ok");
            end while (!inst_data_ok);
        end
    endtask

    task automatic run_data();
        sramx_req_t r;
        word_t      va;
        logic [1:0] off;
        int         t;
        for (int n = 0; n < N_REQ; n++) begin
            r.req   = 1'b1;
            r.wr    = 1'($urandom % 2);
            r.size  = size_t'($urandom % 3);
            r.wdata = $urandom;
            off     = 2'($urandom % 4);
            if (r.size == SIZE_HALF) off[0] = 1'b0;
            if (r.size == SIZE_WORD) off = 2'b00;
            r.addr = 32'h0000_1000 + word_t'(($urandom % 16) << 2) + word_t'(off);
            va = r.addr | (($urandom % 2) ? `KSEG1_BASE : `KSEG0_BASE);
            data_exp_pa   = r.addr;
            data_exp_id   = (va >= `KSEG1_BASE) ? axi_id_t'(CH_UNCACHED) : axi_id_t'(CH_DATA);
            data_exp_size = r.size;
            data_exp_strb = strobe_of(r.size, off);
            @(posedge aclk);
            data_req   <= 1'b1;
            data_wr    <= r.wr;
            data_size  <= r.size;
            data_addr  <= va;
            data_wdata <= r.wdata;
            t = 0;
            do begin
                @(negedge aclk);
                t++;
                if (t > TIMEOUT) timed_out("data addr_ok");
            end while (!data_addr_ok);
            data_q.push_back(r);
            @(posedge aclk);
            data_req <= 1'b0;
            t = 0;
            do begin
                @(negedge aclk);
                t++;
                if (t > TIMEOUT) timed_out("data data_ok");
            end while (!data_data_ok);
        end
    endtask

    initial begin
        void'($urandom(32'h5de5_ed39));
        rst_n      = 1'b0;
        inst_req   = 1'b0;
        inst_wr    = 1'b0;
        inst_size  = SIZE_WORD;
        inst_addr  = '0;
        inst_wdata = '0;
        data_req   = 1'b0;
        data_wr    = 1'b0;
        data_size  = SIZE_WORD;
        data_addr  = '0;
        data_wdata = '0;
        rresp      = 2'b00;
        bresp      = 2'b00;
        rlast      = 1'b1;
        repeat (3) begin
            @(negedge aclk);
            check_idle();
        end
        @(posedge aclk);
        rst_n <= 1'b1;
        @(negedge aclk);
        check_idle();
        fork
            run_inst();
            run_data();
        join
        repeat (5) @(posedge aclk);
        if (inst_q.size() != 0 || data_q.size() != 0) begin
            errors++;
            $display("requests still waiting for data_ok at the end");
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+source
source/bridge_pkg.sv
source/sramx_if.sv
source/axi_if.sv
source/addr_dispatch.sv
source/sramx_to_axi.sv
source/axi_arbiter.sv
source/sramx_axi_bridge.sv
testbench/tb_bridge.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_bridge -o tb_bridge &&
    out="$(./obj_dir/tb_bridge)" &&
    echo "$out" &&
    echo "$out" | grep -qx "TEST PASS" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
